//--- flist.f
+incdir+hdl
hdl/rv_core_pkg.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/register_file.sv
hdl/execute_stage.sv
hdl/memory_stage.sv
hdl/rv_core.sv
dv/rv_core_checker.sv
dv/rv_core_tb.sv

//--- Bender.yml
package:
  name: rv_core

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/rv_core_pkg.sv
      - hdl/fetch_stage.sv
      - hdl/decode_stage.sv
      - hdl/register_file.sv
      - hdl/execute_stage.sv
      - hdl/memory_stage.sv
      - hdl/rv_core.sv
      - target: test
        files:
          - dv/rv_core_checker.sv
          - dv/rv_core_tb.sv

//--- dv/rv_core_tb.sv
`default_nettype none

`include "rv_core_defines.svh"

module rv_core_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int unsigned PROG_LEN       = 300;
    localparam int unsigned DMEM_WORDS     = 2 ** `DMEM_AW;
    localparam int unsigned RESET_CYCLES   = 5;
    localparam int unsigned DRAIN_CYCLES   = 8;
    localparam int unsigned TIMEOUT_CYCLES = 4 * PROG_LEN + 100;
    localparam logic [31:0] SEED           = 32'h71ff_347e;
    localparam logic [31:0] NOP_WORD       = 32'h0000_0013; // ADDI x0,x0,0
    localparam logic [6:0]  OPC_LOAD       = 7'b0000011;
    localparam logic [6:0]  OPC_STORE      = 7'b0100011;
    localparam logic [6:0]  OPC_IMM        = 7'b0010011;
    localparam logic [6:0]  OPC_REG        = 7'b0110011;
    localparam logic [6:0]  OPC_LUI        = 7'b0110111;

    typedef struct packed {
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       data;
    } expected_write_t;

    logic                   clk = 1'b0;
    logic                   reset;
    logic [`XLEN-1:0]       imem_rdata;
    logic [`XLEN-1:0]       imem_addr;
    logic                   wb_valid;
    logic [`REG_ADDR_W-1:0] wb_rd;
    logic [`XLEN-1:0]       wb_data;

    logic [31:0]     program_mem [PROG_LEN];
    expected_write_t expected_q [$];
    logic [31:0]     prev_addr;

    rv_core rv_core_i (
        .clk        (clk),
        .reset      (reset),
        .imem_rdata (imem_rdata),
        .imem_addr  (imem_addr),
        .wb_valid   (wb_valid),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data)
    );

    bind rv_core rv_core_checker rv_core_checker_i (
        .clk       (clk),
        .reset     (reset),
        .imem_addr (imem_addr),
        .wb_valid  (wb_valid),
        .wb_rd     (wb_rd)
    );

    always #50 clk = ~clk;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Simulation FAILED");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            abort_run($sformatf("FAIL at %0t ns: %s, got %h expected %h",
                                $time, what, actual, expected));
        end
    endtask

    function automatic logic [31:0] sext12(input logic [11:0] value);
        return {{20{value[11]}}, value};
    endfunction

    // ISA semantics of the kept subset with funct3 100 as NOR
    function automatic logic [31:0] model_alu(input logic [2:0] funct3, input logic sub,
                                              input logic [31:0] a, input logic [31:0] b);
        case (funct3)
            3'b000:  return sub ? a - b : a + b;
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b100:  return ~(a | b);
            3'b110:  return a | b;
            default: return a & b; // AND and the unused codes
        endcase
    endfunction

    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        if (addr[31:2] < PROG_LEN) begin
            return program_mem[addr[31:2]];
        end
        return NOP_WORD;
    endfunction

    task automatic build_program();
        int unsigned kind;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  funct3;
        logic [6:0]  funct7;
        logic [11:0] imm;
        for (int i = 0; i < PROG_LEN; i++) begin
            kind   = $urandom_range(99);
            rd     = 5'($urandom_range(7)); // x0..x7 for dense dependencies
            rs1    = 5'($urandom_range(7));
            rs2    = 5'($urandom_range(7));
            funct3 = 3'($urandom_range(7));
            funct7 = ($urandom_range(1) != 0) ? 7'h20 : 7'h00;
            imm    = 12'($urandom);
            if (kind < 35) begin
                program_mem[i] = {funct7, rs2, rs1, funct3, rd, OPC_REG};
            end else if (kind < 65) begin
                program_mem[i] = {imm, rs1, funct3, rd, OPC_IMM};
            end else begin
                imm = {imm[11:8], 3'b000, imm[4:0]}; // Eight words with unaligned offsets too
                if (kind < 78) begin
                    program_mem[i] = {imm, 5'd0, 3'b010, rd, OPC_LOAD};
                end else if (kind < 92) begin
                    program_mem[i] = {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], OPC_STORE};
                end else begin
                    program_mem[i] = {imm, rs1, funct3, rd, OPC_LUI}; // Must not write
                end
            end
        end
    endtask

    task automatic run_model();
        logic [31:0]     regs [32];
        logic [31:0]     dmem [DMEM_WORDS];
        logic [31:0]     word;
        logic [31:0]     a;
        logic [31:0]     b;
        logic [31:0]     addr;
        logic [31:0]     result;
        logic            writes;
        expected_write_t entry;
        for (int r = 0; r < 32; r++) begin
            regs[r] = '0;
        end
        for (int w = 0; w < DMEM_WORDS; w++) begin
            dmem[w] = '0;
        end
        for (int i = 0; i < PROG_LEN; i++) begin
            word   = program_mem[i];
            a      = regs[word[19:15]];
            b      = regs[word[24:20]];
            result = '0;
            writes = 1'b0;
            case (word[6:0])
                OPC_REG: begin
                    result = model_alu(word[14:12], word[30], a, b);
                    writes = 1'b1;
                end
                OPC_IMM: begin
                    result = model_alu(word[14:12], 1'b0, a, sext12(word[31:20]));
                    writes = 1'b1;
                end
                OPC_LOAD: begin
                    addr   = a + sext12(word[31:20]);
                    result = dmem[addr[`DMEM_AW+1:2]];
                    writes = 1'b1;
                end
                OPC_STORE: begin
                    addr = a + sext12({word[31:25], word[11:7]});
                    dmem[addr[`DMEM_AW+1:2]] = b;
                end
                default: begin
                end
            endcase
            if (writes && (word[11:7] != 5'd0)) begin
                regs[word[11:7]] = result;
                entry.rd         = word[11:7];
                entry.data       = result;
                expected_q.push_back(entry);
            end
        end
    endtask

    // Sample outputs and answer the fetch on the falling edge
    task automatic cycle_step();
        expected_write_t entry;
        @(negedge clk);
        check_value(imem_addr[1:0], 0, "fetch address alignment");
        check_value((imem_addr == prev_addr) || (imem_addr == prev_addr + 32'd4), 1,
                    "fetch address step");
        prev_addr = imem_addr;
        if (wb_valid) begin
            check_value(wb_rd != '0, 1, "write-back to x0");
            check_value(expected_q.size() != 0, 1, "write-back beyond the model's writes");
            entry = expected_q.pop_front();
            check_value(wb_rd, entry.rd, "write-back rd");
            check_value(wb_data, entry.data, "write-back data");
        end
        imem_rdata = fetch_word(imem_addr);
    endtask

    initial begin
        int unsigned cycles;
        reset      = 1'b1;
        imem_rdata = NOP_WORD;
        void'($urandom(SEED));
        build_program();
        run_model();
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        check_value(imem_addr, `RESET_PC, "fetch address after reset");
        check_value(wb_valid, 0, "write-back valid after reset");
        prev_addr  = imem_addr;
        imem_rdata = fetch_word(imem_addr);
        cycles     = 0;
        while ((expected_q.size() != 0) || (imem_addr[31:2] < PROG_LEN + 4)) begin
            cycle_step();
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                abort_run("Timeout: the program did not drain from the pipeline");
            end
        end
        repeat (DRAIN_CYCLES) cycle_step(); // Catch stray late write-backs
        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/rv_core_checker.sv
`default_nettype none

`include "rv_core_defines.svh"

module rv_core_checker (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [`XLEN-1:0]       imem_addr,
    input  logic                   wb_valid,
    input  logic [`REG_ADDR_W-1:0] wb_rd
);

    timeunit 1ns;
    timeprecision 1ps;

    // A write-back always targets a real register
    wb_rd_nonzero: assert property (@(posedge clk) disable iff (reset)
        wb_valid |-> (wb_rd != '0))
        else $error("write-back valid with rd equal to x0");

    fetch_aligned: assert property (@(posedge clk) disable iff (reset)
        imem_addr[1:0] == 2'b00)
        else $error("fetch address not word aligned");

    // Only a stall may hold the PC, nothing jumps
    fetch_step: assert property (@(posedge clk) disable iff (reset)
        !$past(reset) |-> ((imem_addr == $past(imem_addr)) ||
                           (imem_addr == $past(imem_addr) + `XLEN'd4)))
        else $error("fetch address neither held nor advanced by 4");

endmodule

`default_nettype wire

//--- hdl/rv_core.sv
`default_nettype none

`include "rv_core_defines.svh"

module rv_core (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [`XLEN-1:0]       imem_rdata,
    output logic [`XLEN-1:0]       imem_addr,
    output logic                   wb_valid,
    output logic [`REG_ADDR_W-1:0] wb_rd,
    output logic [`XLEN-1:0]       wb_data
);

    import rv_core_pkg::*;

    if_id_t                 if_id;
    id_ex_t                 id_ex;
    ex_mem_t                ex_mem;
    wb_t                    wb;
    logic                   stall;
    logic [`REG_ADDR_W-1:0] rs1_addr;
    logic [`REG_ADDR_W-1:0] rs2_addr;
    logic [`XLEN-1:0]       rs1_data;
    logic [`XLEN-1:0]       rs2_data;

    fetch_stage fetch_stage_i (
        .clk        (clk),
        .reset      (reset),
        .stall      (stall),
        .imem_rdata (imem_rdata),
        .imem_addr  (imem_addr),
        .if_id      (if_id)
    );

    decode_stage decode_stage_i (
        .clk      (clk),
        .reset    (reset),
        .if_id    (if_id),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .stall    (stall),
        .id_ex    (id_ex)
    );

    register_file register_file_i (
        .clk      (clk),
        .reset    (reset),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .wb       (wb),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    execute_stage execute_stage_i (
        .clk    (clk),
        .reset  (reset),
        .id_ex  (id_ex),
        .wb     (wb), // Second forwarding source
        .ex_mem (ex_mem)
    );

    memory_stage memory_stage_i (
        .clk    (clk),
        .reset  (reset),
        .ex_mem (ex_mem),
        .wb     (wb)
    );

    // Observation port for the write-back stream
    assign wb_valid = wb.valid;
    assign wb_rd    = wb.rd;
    assign wb_data  = wb.data;

endmodule

`default_nettype wire

//--- hdl/memory_stage.sv
`default_nettype none

`include "rv_core_defines.svh"

module memory_stage (
    input  logic                 clk,
    input  logic                 reset,
    input  rv_core_pkg::ex_mem_t ex_mem,
    output rv_core_pkg::wb_t     wb
);

    localparam int unsigned DMEM_WORDS = 2 ** `DMEM_AW;

    logic [`XLEN-1:0]    dmem [DMEM_WORDS];
    logic [`DMEM_AW-1:0] dmem_idx;
    logic [`XLEN-1:0]    dmem_rdata;

    // Word index, byte offset dropped
    assign dmem_idx   = ex_mem.alu_result[`DMEM_AW+1:2];
    assign dmem_rdata = dmem[dmem_idx];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < DMEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
        end else if (ex_mem.valid && ex_mem.mem_write) begin
            dmem[dmem_idx] <= ex_mem.store_data;
        end
    end

    // MEM/WB register, load data or ALU result
    always_ff @(posedge clk) begin
        if (reset) begin
            wb.valid <= 1'b0;
        end else begin
            wb.valid <= ex_mem.valid && ex_mem.reg_write && (ex_mem.rd != '0);
            wb.rd    <= ex_mem.rd;
            wb.data  <= ex_mem.mem_read ? dmem_rdata : ex_mem.alu_result;
        end
    end

endmodule

`default_nettype wire

//--- hdl/execute_stage.sv
`default_nettype none

`include "rv_core_defines.svh"

module execute_stage (
    input  logic                 clk,
    input  logic                 reset,
    input  rv_core_pkg::id_ex_t  id_ex,
    input  rv_core_pkg::wb_t     wb,
    output rv_core_pkg::ex_mem_t ex_mem
);

    import rv_core_pkg::*;

    logic             mem_fwd_ok;
    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] rs2_fwd;
    logic [`XLEN-1:0] op_b;
    alu_ctrl_e        alu_ctrl;
    logic [`XLEN-1:0] alu_result;

    // EX/MEM may hold a result the current instruction needs
    assign mem_fwd_ok = ex_mem.valid && ex_mem.reg_write && (ex_mem.rd != '0);

    // Newest value first: EX/MEM, then write-back, then the register read
    function automatic logic [`XLEN-1:0] forward_operand(
        input logic [`REG_ADDR_W-1:0] rs,
        input logic [`XLEN-1:0]       reg_data
    );
        if (mem_fwd_ok && (ex_mem.rd == rs)) begin
            return ex_mem.alu_result;
        end else if (wb.valid && (wb.rd == rs)) begin
            return wb.data;
        end
        return reg_data;
    endfunction

    always_comb begin
        op_a    = forward_operand(id_ex.rs1, id_ex.rs1_data);
        rs2_fwd = forward_operand(id_ex.rs2, id_ex.rs2_data);
        op_b    = id_ex.ctrl.alu_src ? id_ex.imm : rs2_fwd;
    end

    // ALU control
    always_comb begin
        alu_ctrl = ALU_ADD; // Loads and stores
        if (id_ex.ctrl.alu_op != ALU_OP_ADD) begin
            case (id_ex.funct3)
                3'b000: begin
                    if ((id_ex.ctrl.alu_op == ALU_OP_REG) && id_ex.sub_bit) begin
                        alu_ctrl = ALU_SUB;
                    end else begin
                        alu_ctrl = ALU_ADD;
                    end
                end
                3'b010:  alu_ctrl = ALU_SLT;
                3'b100:  alu_ctrl = ALU_NOR;
                3'b110:  alu_ctrl = ALU_OR;
                3'b111:  alu_ctrl = ALU_AND;
                default: alu_ctrl = ALU_AND; // Unused codes
            endcase
        end
    end

    always_comb begin
        case (alu_ctrl)
            ALU_AND: alu_result = op_a & op_b;
            ALU_OR:  alu_result = op_a | op_b;
            ALU_ADD: alu_result = op_a + op_b;
            ALU_SUB: alu_result = op_a - op_b;
            ALU_SLT: alu_result = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_NOR: alu_result = ~(op_a | op_b);
            default: alu_result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ex_mem.valid     <= 1'b0;
            ex_mem.mem_read  <= 1'b0;
            ex_mem.mem_write <= 1'b0;
            ex_mem.reg_write <= 1'b0;
        end else begin
            ex_mem.valid      <= id_ex.valid;
            ex_mem.mem_read   <= id_ex.valid && id_ex.ctrl.mem_read;
            ex_mem.mem_write  <= id_ex.valid && id_ex.ctrl.mem_write;
            ex_mem.reg_write  <= id_ex.valid && id_ex.ctrl.reg_write;
            ex_mem.rd         <= id_ex.rd;
            ex_mem.alu_result <= alu_result;
            ex_mem.store_data <= rs2_fwd; // Forwarded, not the stale read
        end
    end

endmodule

`default_nettype wire

//--- hdl/register_file.sv
`default_nettype none

`include "rv_core_defines.svh"

module register_file (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [`REG_ADDR_W-1:0] rs1_addr,
    input  logic [`REG_ADDR_W-1:0] rs2_addr,
    input  rv_core_pkg::wb_t       wb,
    output logic [`XLEN-1:0]       rs1_data,
    output logic [`XLEN-1:0]       rs2_data
);

    localparam int unsigned NUM_REGS = 2 ** `REG_ADDR_W;

    logic [`XLEN-1:0] regs [1:NUM_REGS-1]; // x0 has no storage

    // x0 reads zero, a write in flight wins over the stored value
    function automatic logic [`XLEN-1:0] read_port(input logic [`REG_ADDR_W-1:0] addr);
        if (addr == '0) begin
            return '0;
        end else if (wb.valid && (wb.rd == addr)) begin
            return wb.data;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rs1_data = read_port(rs1_addr);
        rs2_data = read_port(rs2_addr);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid && (wb.rd != '0)) begin
            regs[wb.rd] <= wb.data;
        end
    end

endmodule

`default_nettype wire

//--- hdl/decode_stage.sv
`default_nettype none

`include "rv_core_defines.svh"

module decode_stage (
    input  logic                   clk,
    input  logic                   reset,
    input  rv_core_pkg::if_id_t    if_id,
    input  logic [`XLEN-1:0]       rs1_data,
    input  logic [`XLEN-1:0]       rs2_data,
    output logic [`REG_ADDR_W-1:0] rs1_addr,
    output logic [`REG_ADDR_W-1:0] rs2_addr,
    output logic                   stall,
    output rv_core_pkg::id_ex_t    id_ex
);

    import rv_core_pkg::*;

    instr_t           instr;
    ctrl_t            ctrl;
    logic [`XLEN-1:0] imm;
    logic             load_hazard;

    assign instr    = if_id.instr;
    assign rs1_addr = instr.ri.rs1;
    assign rs2_addr = instr.ri.rs2;

    // Main control
    always_comb begin
        ctrl           = '0;
        ctrl.alu_op    = ALU_OP_ADD;
        if (if_id.valid) begin
            case (instr.ri.opcode)
                OP_LOAD: begin
                    ctrl.alu_src   = 1'b1;
                    ctrl.mem_read  = 1'b1;
                    ctrl.reg_write = 1'b1;
                end
                OP_STORE: begin
                    ctrl.alu_src   = 1'b1;
                    ctrl.mem_write = 1'b1;
                end
                OP_IMM: begin
                    ctrl.alu_src   = 1'b1;
                    ctrl.reg_write = 1'b1;
                    ctrl.alu_op    = ALU_OP_IMM;
                end
                OP_REG: begin
                    ctrl.reg_write = 1'b1;
                    ctrl.alu_op    = ALU_OP_REG;
                end
                default: begin
                    // Anything else passes through as a no-op
                end
            endcase
        end
    end

    // Sign-extended immediate, S layout only for stores
    always_comb begin
        if (instr.ri.opcode == OP_STORE) begin
            imm = {{(`XLEN-12){instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
        end else begin
            imm = {{(`XLEN-12){instr.ri.funct7[6]}}, instr.ri.funct7, instr.ri.rs2};
        end
    end

    // Load in EX whose result the next instruction needs
    assign load_hazard = id_ex.valid && id_ex.ctrl.mem_read && (id_ex.rd != '0) &&
                         ((id_ex.rd == rs1_addr) || (id_ex.rd == rs2_addr));
    assign stall = if_id.valid && load_hazard;

    always_ff @(posedge clk) begin
        if (reset) begin
            id_ex.valid <= 1'b0;
            id_ex.ctrl  <= '0;
        end else if (stall) begin
            id_ex.valid <= 1'b0; // Bubble
            id_ex.ctrl  <= '0;
        end else begin
            id_ex.valid    <= if_id.valid;
            id_ex.ctrl     <= ctrl;
            id_ex.rs1      <= rs1_addr;
            id_ex.rs2      <= rs2_addr;
            id_ex.rd       <= instr.ri.rd;
            id_ex.rs1_data <= rs1_data;
            id_ex.rs2_data <= rs2_data;
            id_ex.imm      <= imm;
            id_ex.funct3   <= instr.ri.funct3;
            id_ex.sub_bit  <= instr.ri.funct7[5]; // Only meaningful for R-type
        end
    end

endmodule

`default_nettype wire

//--- hdl/fetch_stage.sv
`default_nettype none

`include "rv_core_defines.svh"

module fetch_stage (
    input  logic                clk,
    input  logic                reset,
    input  logic                stall,
    input  logic [`XLEN-1:0]    imem_rdata,
    output logic [`XLEN-1:0]    imem_addr,
    output rv_core_pkg::if_id_t if_id
);

    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] pc_next;

    assign imem_addr = pc; // Instruction comes back in the same cycle

    // Hold on a load-use stall
    assign pc_next = stall ? pc : pc + `XLEN'd4;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `RESET_PC;
        end else begin
            pc <= pc_next;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            if_id.valid <= 1'b0;
        end else if (!stall) begin
            if_id.valid <= 1'b1;
            if_id.pc    <= pc;
            if_id.instr <= imem_rdata; // Raw word, decode picks the view
        end
    end

endmodule

`default_nettype wire

//--- hdl/rv_core_pkg.sv
`default_nettype none

`include "rv_core_defines.svh"

package rv_core_pkg;

    typedef enum logic [6:0] {
        OP_LOAD  = 7'b0000011,
        OP_STORE = 7'b0100011,
        OP_IMM   = 7'b0010011,
        OP_REG   = 7'b0110011
    } opcode_e;

    typedef enum logic [1:0] {
        ALU_OP_ADD = 2'b00, // Address calculation
        ALU_OP_REG = 2'b10, // funct7[5] picks SUB
        ALU_OP_IMM = 2'b11  // funct7 is immediate bits here
    } alu_op_e;

    typedef enum logic [3:0] {
        ALU_AND = 4'b0000,
        ALU_OR  = 4'b0001,
        ALU_ADD = 4'b0010,
        ALU_SUB = 4'b0110,
        ALU_SLT = 4'b0111,
        ALU_NOR = 4'b1100
    } alu_ctrl_e;

    typedef struct packed {
        logic [6:0]             funct7;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [`REG_ADDR_W-1:0] rd;
        logic [6:0]             opcode;
    } instr_ri_t;

    typedef struct packed {
        logic [6:0]             imm_hi;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [4:0]             imm_lo;
        logic [6:0]             opcode;
    } instr_s_t;

    // Same word, two field layouts
    typedef union packed {
        instr_ri_t ri;
        instr_s_t  s;
    } instr_t;

    typedef struct packed {
        logic    alu_src;   // Immediate as operand B
        logic    mem_read;
        logic    mem_write;
        logic    reg_write;
        alu_op_e alu_op;
    } ctrl_t;

    typedef struct packed {
        logic             valid;
        logic [`XLEN-1:0] pc;
        instr_t           instr;
    } if_id_t;

    typedef struct packed {
        logic                   valid;
        ctrl_t                  ctrl;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       rs1_data;
        logic [`XLEN-1:0]       rs2_data;
        logic [`XLEN-1:0]       imm;
        logic [2:0]             funct3;
        logic                   sub_bit;
    } id_ex_t;

    typedef struct packed {
        logic                   valid;
        logic                   mem_read;
        logic                   mem_write;
        logic                   reg_write;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       alu_result;
        logic [`XLEN-1:0]       store_data;
    } ex_mem_t;

    typedef struct packed {
        logic                   valid; // Register write to a nonzero rd
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       data;
    } wb_t;

endpackage

`default_nettype wire

//--- hdl/rv_core_defines.svh
`ifndef RV_CORE_DEFINES_SVH
`define RV_CORE_DEFINES_SVH

// Machine word and register file geometry
`define XLEN 32
`define REG_ADDR_W 5

// Data memory index width, 64 words
`define DMEM_AW 6

// Fetch address after reset
`define RESET_PC 32'h0000_0000

`endif
